//--- design/zorro_bus_pkg.sv
// zorro iii bus widths, config-space address, memory-space codes and cycle states
package zorro_bus_pkg;

	// ----------------------------------------
	// bus widths
	// ----------------------------------------
	localparam int BUS_DATA_W = 32;
	localparam int BUS_ADDR_W = 32;
	// one strobe per byte lane, ds3 on d31..d24
	localparam int NDS_W = 4;

	// config space sits at $ff000000, compared on a31..a16
	localparam logic [15:0] CFG_SPACE_HI = 16'hFF00;

	// memory-space codes on fc1..fc0
	// valid when exactly one bit is set
	localparam logic [1:0] FC_USER_DATA = 2'd1;
	localparam logic [1:0] FC_USER_PROG = 2'd2;

	// full-cycle states of the slave
	typedef enum logic [2:0] {
		IDLE,
		MATCH,
		DATA,
		WRITE_POST,
		READ_WAIT,
		DTACK,
		DTACK_ERR
	} zs_state_t;

endpackage

//--- design/card_pkg.sv
// autoconfig register offsets, rom nibbles and local memory opcodes
package card_pkg;

	// register offset is a8..a2 of the config-space address
	localparam int AC_REG_W = 7;
	// byte offset width, a8..a0
	localparam int AC_OFS_W = AC_REG_W + 2;

	// write-only registers, byte offsets
	localparam logic [AC_OFS_W-1:0] AC_BASE_OFS = 9'h044;
	localparam logic [AC_OFS_W-1:0] AC_SHUTUP_OFS = 9'h04C;

	// ----------------------------------------
	// rom nibbles, high nibble at a8=0, low at a8=1
	// ----------------------------------------
	// er_type: zorro iii, link into free memory, size from flags
	localparam logic [3:0] AC_ROM_TYPE_HI = 4'hA;
	localparam logic [3:0] AC_ROM_TYPE_LO = 4'h2;
	// er_product
	localparam logic [3:0] AC_ROM_PROD_HI = 4'h0;
	localparam logic [3:0] AC_ROM_PROD_LO = 4'h7;
	// er_flags: extended size, zorro iii space
	localparam logic [3:0] AC_ROM_SIZE_HI = 4'h3;
	localparam logic [3:0] AC_ROM_SIZE_LO = 4'h0;

	// requests seen by the local memory
	typedef enum logic [1:0] {MEM_NOP, MEM_READ, MEM_WRITE} mem_op_t;

endpackage

//--- design/zorro_cycle_fsm.sv
// zorro iii slave cycle fsm: input sampling, address latch, decode and bus strobes
`timescale 1ns/1ps

module zorro_cycle_fsm
	import zorro_bus_pkg::*, card_pkg::*;
#(
	parameter int MEM_AW = 10,
	parameter int DTACK_TIMEOUT = 48
) (
	input  logic                  clk,
	input  logic                  nIORST,
	// bus side
	input  logic                  nFCS_i,
	input  logic                  READ_i,
	input  logic [1:0]            FC_i,
	input  logic [BUS_DATA_W-1:0] ad_i,
	input  logic [NDS_W-1:0]      nDS_i,
	input  logic                  DOE_i,
	output logic                  nSLAVEN_o,
	output logic                  nDTACK_o,
	output logic                  nBERR_o,
	output logic [BUS_DATA_W-1:0] rdata_o,
	output logic                  data_oe_o,
	// autoconfig block
	output logic                  cfg_sel_o,
	output logic                  cfg_wr_o,
	output logic [AC_REG_W-1:0]   reg_ofs_o,
	output logic [BUS_DATA_W-1:0] cfg_wdata_o,
	input  logic [3:0]            cfg_rdata_i,
	input  logic [5:0]            base_hi_i,
	input  logic                  configured_i,
	input  logic                  cfg_active_i,
	// posted-write queue
	output logic                  wr_push_o,
	output logic [MEM_AW-1:0]     wr_addr_o,
	output logic [BUS_DATA_W-1:0] wr_data_o,
	output logic [NDS_W-1:0]      wr_be_o,
	input  logic                  wr_full_i,
	input  logic                  wr_empty_i,
	// memory read port
	output logic                  rd_req_o,
	output logic [MEM_AW-1:0]     rd_addr_o,
	input  logic                  rd_ack_i,
	input  logic [BUS_DATA_W-1:0] rd_data_i
);

	localparam int TMO_W = $clog2(DTACK_TIMEOUT + 1);

	// sampled bus
	logic                  nfcs_s, nfcs_d, read_s, doe_s;
	logic [1:0]            fc_s;
	logic [BUS_DATA_W-1:0] ad_s;
	logic [NDS_W-1:0]      nds_s;
	// latched at cycle start
	logic [BUS_ADDR_W-1:0] addr_q;
	logic                  read_q, cfg_q;
	// write data held for the queue or autoconfig
	logic [BUS_DATA_W-1:0] wdata_q;
	logic [NDS_W-1:0]      be_q;
	zs_state_t             state_q, state_d;
	logic [TMO_W-1:0]      tmo_cnt;
	logic                  nslaven_r;
	logic                  fcs_start, fc_ok, cfg_hit, card_hit;

	// ----------------------------------------
	// one register stage on every bus input
	// ----------------------------------------
	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			nfcs_s <= 1'b1;
			nfcs_d <= 1'b1;
			doe_s <= 1'b0;
			nds_s <= '1;
		end else begin
			nfcs_s <= nFCS_i;
			nfcs_d <= nfcs_s;
			doe_s <= DOE_i;
			nds_s <= nDS_i;
		end
	end

	always_ff @(posedge clk) begin
		read_s <= READ_i;
		fc_s <= FC_i;
		ad_s <= ad_i;
	end

	// first sampled clock with /fcs low
	assign fcs_start = !nfcs_s && nfcs_d;
	// user data or user program space only
	assign fc_ok = (fc_s == FC_USER_DATA) || (fc_s == FC_USER_PROG);
	assign cfg_hit = cfg_active_i && (ad_s[BUS_ADDR_W-1 -: 16] == CFG_SPACE_HI);
	assign card_hit = configured_i && (ad_s[BUS_ADDR_W-1 -: 6] == base_hi_i);

	// ----------------------------------------
	// cycle state machine
	// ----------------------------------------
	always_comb begin
		state_d = state_q;
		// master ends every cycle by raising /fcs
		if (nfcs_s) begin
			state_d = IDLE;
		end else begin
			case (state_q)
				IDLE:
					if (fcs_start && fc_ok && (cfg_hit || card_hit))
						state_d = MATCH;
				MATCH:
					if (doe_s)
						state_d = DATA;
				DATA:
					if (read_q)
						state_d = cfg_q ? DTACK : READ_WAIT;
					else if (nds_s != '1)
						state_d = WRITE_POST;
				// full queue holds the master off
				WRITE_POST:
					if (cfg_q || !wr_full_i)
						state_d = DTACK;
				READ_WAIT:
					if (rd_ack_i)
						state_d = DTACK;
				DTACK:
					if (tmo_cnt == TMO_W'(DTACK_TIMEOUT - 1))
						state_d = DTACK_ERR;
				// stays until /fcs rises
				DTACK_ERR:
					state_d = DTACK_ERR;
				default:
					state_d = IDLE;
			endcase
		end
	end

	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			state_q <= IDLE;
			tmo_cnt <= '0;
			nslaven_r <= 1'b1;
			read_q <= 1'b0;
			cfg_q <= 1'b0;
		end else begin
			state_q <= state_d;
			// counts held dtack cycles only
			tmo_cnt <= (state_q == DTACK) ? tmo_cnt + 1'b1 : '0;
			// released on the clock that sees /fcs high
			nslaven_r <= nfcs_s || (state_q == IDLE);
			if (fcs_start) begin
				read_q <= read_s;
				cfg_q <= cfg_hit;
			end
		end
	end

	// address, write data and read data
	always_ff @(posedge clk) begin
		if (fcs_start)
			addr_q <= ad_s;
		if (state_q == DATA && !read_q && nds_s != '1) begin
			wdata_q <= ad_s;
			be_q <= nds_s;
		end
		// config nibble on d31..d28, rest reads as ones
		if (state_q == DATA && read_q && cfg_q)
			rdata_o <= {cfg_rdata_i, {(BUS_DATA_W-4){1'b1}}};
		else if (state_q == READ_WAIT && rd_ack_i)
			rdata_o <= rd_data_i;
	end

	// bus strobes
	assign nSLAVEN_o = nslaven_r;
	assign nDTACK_o = (state_q != DTACK);
	assign nBERR_o = (state_q != DTACK_ERR);
	assign data_oe_o = READ_i && DOE_i && !nSLAVEN_o && !nDTACK_o;

	// autoconfig side
	assign cfg_sel_o = cfg_q;
	assign reg_ofs_o = addr_q[8:2];
	assign cfg_wr_o = (state_q == WRITE_POST) && cfg_q;
	assign cfg_wdata_o = wdata_q;

	// one push per write, only with room
	assign wr_push_o = (state_q == WRITE_POST) && !cfg_q && !wr_full_i;
	assign wr_addr_o = addr_q[MEM_AW+1:2];
	assign wr_data_o = wdata_q;
	assign wr_be_o = be_q;

	// reads wait for the queue to drain
	assign rd_req_o = (state_q == READ_WAIT) && wr_empty_i;
	assign rd_addr_o = addr_q[MEM_AW+1:2];

endmodule

//--- design/autoconfig_regs.sv
// autoconfig rom, base address register and configuration chain state
`timescale 1ns/1ps

module autoconfig_regs
	import card_pkg::*;
(
	input  logic                clk,
	input  logic                nIORST,
	input  logic                nCFGIN_i,
	input  logic                cfg_sel_i,
	input  logic                cfg_wr_i,
	input  logic [AC_REG_W-1:0] reg_ofs_i,
	input  logic [31:0]         cfg_wdata_i,
	output logic [3:0]          cfg_rdata_o,
	output logic [5:0]          base_hi_o,
	output logic                configured_o,
	output logic                cfg_active_o,
	output logic                nCFGOUT_o
);

	logic                configured_q, shutup_q;
	logic [5:0]          base_q;
	logic [AC_OFS_W-1:0] ofs;
	logic [3:0]          rom_nib;
	logic                base_wr, shutup_wr;

	// back to a byte offset, a1..a0 always zero
	assign ofs = {reg_ofs_i, 2'b00};
	assign base_wr = cfg_sel_i && cfg_wr_i && (ofs == AC_BASE_OFS);
	assign shutup_wr = cfg_sel_i && cfg_wr_i && (ofs == AC_SHUTUP_OFS);

	// ----------------------------------------
	// rom, one nibble per read
	// ----------------------------------------
	always_comb begin
		case (ofs)
			9'h000:  rom_nib = AC_ROM_TYPE_HI;
			9'h100:  rom_nib = AC_ROM_TYPE_LO;
			9'h004:  rom_nib = AC_ROM_PROD_HI;
			9'h104:  rom_nib = AC_ROM_PROD_LO;
			9'h008:  rom_nib = AC_ROM_SIZE_HI;
			9'h108:  rom_nib = AC_ROM_SIZE_LO;
			// unused registers float high
			default: rom_nib = 4'hF;
		endcase
	end

	assign cfg_rdata_o = cfg_sel_i ? rom_nib : 4'hF;

	// chain state, cleared by /iorst
	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			configured_q <= 1'b0;
			shutup_q <= 1'b0;
		end else begin
			if (base_wr)
				configured_q <= 1'b1;
			if (shutup_wr)
				shutup_q <= 1'b1;
		end
	end

	// a31..a26 of the assigned base
	always_ff @(posedge clk) begin
		if (base_wr)
			base_q <= cfg_wdata_i[31:26];
	end

	assign base_hi_o = base_q;
	assign configured_o = configured_q;
	// answer config space only while first in the chain
	assign cfg_active_o = !configured_q && !shutup_q && !nCFGIN_i;
	// pass the chain on once done
	assign nCFGOUT_o = !(configured_q || shutup_q);

endmodule

//--- design/write_post_fifo.sv
// posted-write queue between the bus fsm and local memory
`timescale 1ns/1ps

module write_post_fifo
	import zorro_bus_pkg::*, card_pkg::*;
#(
	parameter int MEM_AW = 10,
	parameter int FIFO_DEPTH = 4
) (
	input  logic                  clk,
	input  logic                  nIORST,
	input  logic                  wr_push_i,
	input  logic [MEM_AW-1:0]     wr_addr_i,
	input  logic [BUS_DATA_W-1:0] wr_data_i,
	input  logic [NDS_W-1:0]      wr_be_i,
	output logic                  wr_full_o,
	output logic                  wr_empty_o,
	output mem_op_t               mem_op_o,
	output logic [MEM_AW-1:0]     mem_addr_o,
	output logic [BUS_DATA_W-1:0] mem_data_o,
	output logic [NDS_W-1:0]      mem_be_o,
	input  logic                  mem_ack_i
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	// entry storage
	logic [MEM_AW-1:0]     addr_q [FIFO_DEPTH];
	logic [BUS_DATA_W-1:0] data_q [FIFO_DEPTH];
	logic [NDS_W-1:0]      be_q   [FIFO_DEPTH];
	logic [PTR_W-1:0]      wr_ptr, rd_ptr;
	logic [CNT_W-1:0]      count;
	logic                  do_push, do_pop;

	assign wr_full_o = (count == CNT_W'(FIFO_DEPTH));
	assign wr_empty_o = (count == '0);
	assign do_push = wr_push_i && !wr_full_o;
	assign do_pop = mem_ack_i && !wr_empty_o;

	// pointers wrap at depth
	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) begin
			addr_q[wr_ptr] <= wr_addr_i;
			data_q[wr_ptr] <= wr_data_i;
			be_q[wr_ptr] <= wr_be_i;
		end
	end

	// head entry always on offer
	assign mem_op_o = wr_empty_o ? MEM_NOP : MEM_WRITE;
	assign mem_addr_o = addr_q[rd_ptr];
	assign mem_data_o = data_q[rd_ptr];
	assign mem_be_o = be_q[rd_ptr];

endmodule

//--- design/card_memory.sv
// local ram with byte strobes, single-cycle writes and pipelined reads
`timescale 1ns/1ps

module card_memory
	import zorro_bus_pkg::*, card_pkg::*;
#(
	parameter int MEM_AW = 10,
	parameter int MEM_LATENCY = 2
) (
	input  logic                  clk,
	input  logic                  nIORST,
	// write port, fed by the queue
	input  mem_op_t               mem_op_i,
	input  logic [MEM_AW-1:0]     mem_addr_i,
	input  logic [BUS_DATA_W-1:0] mem_data_i,
	input  logic [NDS_W-1:0]      mem_be_i,
	output logic                  mem_ack_o,
	// read port, fed by the fsm
	input  logic                  rd_req_i,
	input  logic [MEM_AW-1:0]     rd_addr_i,
	output logic                  rd_ack_o,
	output logic [BUS_DATA_W-1:0] rd_data_o
);

	logic [BUS_DATA_W-1:0] ram [2**MEM_AW];
	logic [BUS_DATA_W-1:0] data_pipe [MEM_LATENCY];
	logic [MEM_LATENCY-1:0] rd_pipe;
	logic                  rd_busy;
	mem_op_t               op_sel;

	// one read in flight at a time
	assign rd_busy = |rd_pipe;

	// queued writes win over reads
	always_comb begin
		if (mem_op_i == MEM_WRITE)
			op_sel = MEM_WRITE;
		else if (rd_req_i && !rd_busy)
			op_sel = MEM_READ;
		else
			op_sel = MEM_NOP;
	end

	always_ff @(posedge clk) begin
		// low strobe enables its byte lane
		if (op_sel == MEM_WRITE) begin
			for (int b = 0; b < NDS_W; b++) begin
				if (!mem_be_i[b])
					ram[mem_addr_i][8*b +: 8] <= mem_data_i[8*b +: 8];
			end
		end
		for (int i = MEM_LATENCY - 1; i > 0; i--)
			data_pipe[i] <= data_pipe[i-1];
		if (op_sel == MEM_READ)
			data_pipe[0] <= ram[rd_addr_i];
	end

	// read valid travels with its data
	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			rd_pipe <= '0;
		end else begin
			for (int i = MEM_LATENCY - 1; i > 0; i--)
				rd_pipe[i] <= rd_pipe[i-1];
			rd_pipe[0] <= (op_sel == MEM_READ);
		end
	end

	// write done at the edge, queue pops there too
	assign mem_ack_o = (op_sel == MEM_WRITE);
	assign rd_ack_o = rd_pipe[MEM_LATENCY-1];
	assign rd_data_o = data_pipe[MEM_LATENCY-1];

endmodule

//--- design/zorro_ram_card.sv
// zorro iii ram card top: bus fsm, autoconfig, posted-write queue and local ram
`timescale 1ns/1ps

module zorro_ram_card
	import zorro_bus_pkg::*, card_pkg::*;
#(
	parameter int MEM_AW = 10,
	parameter int MEM_LATENCY = 2,
	parameter int FIFO_DEPTH = 4,
	parameter int DTACK_TIMEOUT = 48
) (
	input  logic                  clk,
	input  logic                  nIORST,
	input  logic                  nFCS_i,
	input  logic                  READ_i,
	input  logic [1:0]            FC_i,
	input  logic [BUS_DATA_W-1:0] ad_i,
	input  logic [NDS_W-1:0]      nDS_i,
	input  logic                  DOE_i,
	input  logic                  nCFGIN_i,
	output logic                  nSLAVEN_o,
	output logic                  nDTACK_o,
	output logic                  nBERR_o,
	output logic                  nCFGOUT_o,
	output logic [BUS_DATA_W-1:0] rdata_o,
	output logic                  data_oe_o
);

	// fsm to autoconfig
	logic                  cfg_sel, cfg_wr, configured, cfg_active;
	logic [AC_REG_W-1:0]   reg_ofs;
	logic [BUS_DATA_W-1:0] cfg_wdata;
	logic [3:0]            cfg_rdata_nibble;
	logic [5:0]            base_hi;
	// fsm to queue
	logic                  wr_push, wr_full, wr_empty;
	logic [MEM_AW-1:0]     wr_addr;
	logic [BUS_DATA_W-1:0] wr_data;
	logic [NDS_W-1:0]      wr_be;
	// queue to memory
	mem_op_t               mem_op;
	logic [MEM_AW-1:0]     mem_addr;
	logic [BUS_DATA_W-1:0] mem_data;
	logic [NDS_W-1:0]      mem_be;
	logic                  mem_ack;
	// read path
	logic                  rd_req, rd_ack;
	logic [MEM_AW-1:0]     rd_addr;
	logic [BUS_DATA_W-1:0] rd_data;

	// ----------------------------------------
	// producer: bus cycles
	// ----------------------------------------
	zorro_cycle_fsm #(
		.MEM_AW        (MEM_AW),
		.DTACK_TIMEOUT (DTACK_TIMEOUT)
	) u_fsm (
		.clk          (clk),
		.nIORST       (nIORST),
		.nFCS_i       (nFCS_i),
		.READ_i       (READ_i),
		.FC_i         (FC_i),
		.ad_i         (ad_i),
		.nDS_i        (nDS_i),
		.DOE_i        (DOE_i),
		.nSLAVEN_o    (nSLAVEN_o),
		.nDTACK_o     (nDTACK_o),
		.nBERR_o      (nBERR_o),
		.rdata_o      (rdata_o),
		.data_oe_o    (data_oe_o),
		.cfg_sel_o    (cfg_sel),
		.cfg_wr_o     (cfg_wr),
		.reg_ofs_o    (reg_ofs),
		.cfg_wdata_o  (cfg_wdata),
		.cfg_rdata_i  (cfg_rdata_nibble),
		.base_hi_i    (base_hi),
		.configured_i (configured),
		.cfg_active_i (cfg_active),
		.wr_push_o    (wr_push),
		.wr_addr_o    (wr_addr),
		.wr_data_o    (wr_data),
		.wr_be_o      (wr_be),
		.wr_full_i    (wr_full),
		.wr_empty_i   (wr_empty),
		.rd_req_o     (rd_req),
		.rd_addr_o    (rd_addr),
		.rd_ack_i     (rd_ack),
		.rd_data_i    (rd_data)
	);

	// config chain and base register
	autoconfig_regs u_autoconfig (
		.clk          (clk),
		.nIORST       (nIORST),
		.nCFGIN_i     (nCFGIN_i),
		.cfg_sel_i    (cfg_sel),
		.cfg_wr_i     (cfg_wr),
		.reg_ofs_i    (reg_ofs),
		.cfg_wdata_i  (cfg_wdata),
		.cfg_rdata_o  (cfg_rdata_nibble),
		.base_hi_o    (base_hi),
		.configured_o (configured),
		.cfg_active_o (cfg_active),
		.nCFGOUT_o    (nCFGOUT_o)
	);

	// buffer: posted writes
	write_post_fifo #(
		.MEM_AW     (MEM_AW),
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_wr_fifo (
		.clk        (clk),
		.nIORST     (nIORST),
		.wr_push_i  (wr_push),
		.wr_addr_i  (wr_addr),
		.wr_data_i  (wr_data),
		.wr_be_i    (wr_be),
		.wr_full_o  (wr_full),
		.wr_empty_o (wr_empty),
		.mem_op_o   (mem_op),
		.mem_addr_o (mem_addr),
		.mem_data_o (mem_data),
		.mem_be_o   (mem_be),
		.mem_ack_i  (mem_ack)
	);

	// consumer: local ram
	card_memory #(
		.MEM_AW      (MEM_AW),
		.MEM_LATENCY (MEM_LATENCY)
	) u_mem (
		.clk        (clk),
		.nIORST     (nIORST),
		.mem_op_i   (mem_op),
		.mem_addr_i (mem_addr),
		.mem_data_i (mem_data),
		.mem_be_i   (mem_be),
		.mem_ack_o  (mem_ack),
		.rd_req_i   (rd_req),
		.rd_addr_i  (rd_addr),
		.rd_ack_o   (rd_ack),
		.rd_data_o  (rd_data)
	);

endmodule

//--- test/zorro_bus_assert.sv
// concurrent checks on the card's bus strobes and their bind into the top level
`timescale 1ns/1ps

module zorro_bus_assert (
	input logic clk,
	input logic nIORST,
	input logic nFCS_i,
	input logic READ_i,
	input logic nSLAVEN_o,
	input logic nDTACK_o,
	input logic nBERR_o,
	input logic data_oe_o
);

	// dtack only inside a claimed cycle
	dtack_needs_slaven: assert property (@(posedge clk) disable iff (!nIORST)
		!nDTACK_o |-> !nSLAVEN_o)
		else $error("nDTACK_o low while nSLAVEN_o high");

	// bus error only straight out of a held dtack and never together with it
	berr_excludes_dtack: assert property (@(posedge clk) disable iff (!nIORST)
		!nBERR_o |-> nDTACK_o && (!$past(nDTACK_o) || !$past(nBERR_o)))
		else $error("nBERR_o low without a held nDTACK_o before it or together with it");

	// data drivers only on reads that were reads a clock earlier too
	oe_only_on_read: assert property (@(posedge clk) disable iff (!nIORST)
		data_oe_o |-> READ_i && $past(READ_i))
		else $error("data_oe_o high outside a read cycle");

	// input stage plus one clock to release slaven
	slaven_release: assert property (@(posedge clk) disable iff (!nIORST)
		$past(nFCS_i, 2) |-> nSLAVEN_o)
		else $error("nSLAVEN_o still low after nFCS_i release");

endmodule

bind zorro_ram_card zorro_bus_assert u_bus_assert (
	.clk       (clk),
	.nIORST    (nIORST),
	.nFCS_i    (nFCS_i),
	.READ_i    (READ_i),
	.nSLAVEN_o (nSLAVEN_o),
	.nDTACK_o  (nDTACK_o),
	.nBERR_o   (nBERR_o),
	.data_oe_o (data_oe_o)
);

//--- test/tb_zorro_ram_card.sv
// ram card testbench with clock, reset, bus-master tasks, pattern replay and checks
`timescale 1ns/1ps

module tb_zorro_ram_card;

	localparam int MEM_AW = 10;
	localparam int MEM_LATENCY = 2;
	localparam int FIFO_DEPTH = 4;
	localparam int DTACK_TIMEOUT = 48;
	localparam int MEM_WORDS = 1 << MEM_AW;
	// wait limits in clocks
	localparam int SLAVEN_WAIT = 12;
	localparam int DTACK_WAIT = 60;
	localparam int RELEASE_WAIT = 8;

	logic        clk = 1'b0;
	logic        nIORST, nFCS_i, READ_i, DOE_i, nCFGIN_i;
	logic [1:0]  FC_i;
	logic [31:0] ad_i;
	logic [3:0]  nDS_i;
	logic        nSLAVEN_o, nDTACK_o, nBERR_o, nCFGOUT_o, data_oe_o;
	logic [31:0] rdata_o;

	// reference model with one known flag per byte lane
	logic [31:0] sb_data [MEM_WORDS];
	logic [3:0]  sb_known [MEM_WORDS];
	logic [31:0] rng_state = 32'he962;
	int          err_cnt = 0;

	zorro_ram_card #(
		.MEM_AW        (MEM_AW),
		.MEM_LATENCY   (MEM_LATENCY),
		.FIFO_DEPTH    (FIFO_DEPTH),
		.DTACK_TIMEOUT (DTACK_TIMEOUT)
	) UUT (
		.clk       (clk),
		.nIORST    (nIORST),
		.nFCS_i    (nFCS_i),
		.READ_i    (READ_i),
		.FC_i      (FC_i),
		.ad_i      (ad_i),
		.nDS_i     (nDS_i),
		.DOE_i     (DOE_i),
		.nCFGIN_i  (nCFGIN_i),
		.nSLAVEN_o (nSLAVEN_o),
		.nDTACK_o  (nDTACK_o),
		.nBERR_o   (nBERR_o),
		.nCFGOUT_o (nCFGOUT_o),
		.rdata_o   (rdata_o),
		.data_oe_o (data_oe_o)
	);

	// 4 ns period
	always #2 clk = ~clk;

	// ----------------------------------------
	// helpers
	// ----------------------------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// known lanes to a bit mask
	function automatic logic [31:0] lane_mask(input logic [3:0] known);
		logic [31:0] m;
		int b;
		for (b = 0; b < 4; b++)
			m[8*b +: 8] = {8{known[b]}};
		return m;
	endfunction

	// byte address to word index wrapping over the ram
	function automatic int word_index(input logic [31:0] addr);
		return int'((addr >> 2) % 32'(MEM_WORDS));
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		$display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
		err_cnt++;
	endtask

	task automatic report_error(input string msg);
		$display("ERROR t=%0t %s", $time, msg);
		err_cnt++;
	endtask

	task automatic model_write(input logic [31:0] addr, input logic [3:0] nds,
			input logic [31:0] data);
		int idx;
		int b;
		idx = word_index(addr);
		// low strobe writes its lane
		for (b = 0; b < 4; b++) begin
			if (!nds[b]) begin
				sb_data[idx][8*b +: 8] = data[8*b +: 8];
				sb_known[idx][b] = 1'b1;
			end
		end
	endtask

	task automatic check_readback(input logic [31:0] addr, input logic [31:0] act);
		int idx;
		logic [31:0] mask;
		idx = word_index(addr);
		mask = lane_mask(sb_known[idx]);
		if ((act & mask) !== (sb_data[idx] & mask))
			report_mismatch("rdata_o", sb_data[idx] & mask, act & mask);
	endtask

	// ----------------------------------------
	// bus master
	// ----------------------------------------
	// address phase then wait for the card to claim the cycle
	task automatic start_cycle(input logic [31:0] addr, input logic [1:0] fc, input logic rd,
			input int limit, output bit seen, output bit ack_seen);
		int n;
		@(negedge clk);
		ad_i = addr;
		FC_i = fc;
		READ_i = rd;
		nFCS_i = 1'b0;
		seen = 1'b0;
		ack_seen = 1'b0;
		n = 0;
		while (!seen && n < limit) begin
			@(negedge clk);
			seen = !nSLAVEN_o;
			if (!nDTACK_o)
				ack_seen = 1'b1;
			n++;
		end
	endtask

	// data phase starts on the edge that saw slaven
	task automatic data_phase(input logic [3:0] nds, input logic [31:0] data, input int limit,
			output bit seen);
		int n;
		ad_i = data;
		nDS_i = nds;
		DOE_i = 1'b1;
		seen = 1'b0;
		n = 0;
		while (!seen && n < limit) begin
			@(negedge clk);
			seen = !nDTACK_o;
			n++;
		end
	endtask

	task automatic end_cycle();
		int n;
		bit idle;
		nFCS_i = 1'b1;
		DOE_i = 1'b0;
		nDS_i = 4'hF;
		READ_i = 1'b0;
		idle = 1'b0;
		n = 0;
		while (!idle && n < RELEASE_WAIT) begin
			@(negedge clk);
			idle = nSLAVEN_o && nDTACK_o && nBERR_o && !data_oe_o;
			n++;
		end
		if (!idle)
			report_error("bus outputs did not return to idle after nFCS release");
	endtask

	task automatic bus_write(input logic [31:0] addr, input logic [1:0] fc,
			input logic [3:0] nds, input logic [31:0] data, output bit ok);
		bit seen;
		bit ack_early;
		ok = 1'b0;
		start_cycle(addr, fc, 1'b0, SLAVEN_WAIT, seen, ack_early);
		if (ack_early)
			report_error($sformatf("nDTACK low before the data phase of write at %h", addr));
		if (!seen) begin
			report_error($sformatf("no nSLAVEN for write at %h", addr));
		end else begin
			data_phase(nds, data, DTACK_WAIT, seen);
			if (!seen) begin
				report_error($sformatf("no nDTACK for write at %h", addr));
			end else begin
				ok = 1'b1;
				if (data_oe_o !== 1'b0)
					report_mismatch("data_oe_o", 32'd0, {31'd0, data_oe_o});
			end
		end
		end_cycle();
	endtask

	task automatic bus_read(input logic [31:0] addr, input logic [1:0] fc,
			input logic [3:0] nds, output logic [31:0] data, output bit ok);
		bit seen;
		bit ack_early;
		ok = 1'b0;
		data = '0;
		start_cycle(addr, fc, 1'b1, SLAVEN_WAIT, seen, ack_early);
		if (ack_early)
			report_error($sformatf("nDTACK low before the data phase of read at %h", addr));
		if (!seen) begin
			report_error($sformatf("no nSLAVEN for read at %h", addr));
		end else begin
			// address stays on ad_i while the card drives rdata_o
			data_phase(nds, addr, DTACK_WAIT, seen);
			if (!seen) begin
				report_error($sformatf("no nDTACK for read at %h", addr));
			end else begin
				ok = 1'b1;
				data = rdata_o;
				if (data_oe_o !== 1'b1)
					report_mismatch("data_oe_o", 32'd1, {31'd0, data_oe_o});
			end
		end
		end_cycle();
	endtask

	// ----------------------------------------
	// pattern replay
	// ----------------------------------------
	initial begin
		int          fd, code, test_no, pass_cnt, errs_before, i, n;
		string       line, op_name;
		logic [47:0] op;
		logic [31:0] p_addr, p_fc, p_nds, p_wdata, p_exp, a, wdata, rdata;
		logic [3:0]  nds;
		bit          ok, seen, ack_seen;

		nIORST = 1'b0;
		nFCS_i = 1'b1;
		READ_i = 1'b0;
		FC_i = 2'd0;
		ad_i = '0;
		nDS_i = 4'hF;
		DOE_i = 1'b0;
		// first card in the chain
		nCFGIN_i = 1'b0;
		test_no = 0;
		pass_cnt = 0;
		for (i = 0; i < MEM_WORDS; i++)
			sb_known[i] = 4'h0;

		repeat (4) @(negedge clk);
		nIORST = 1'b1;
		@(negedge clk);
		if ({nSLAVEN_o, nDTACK_o, nBERR_o, nCFGOUT_o, data_oe_o} !== 5'b11110)
			report_mismatch("reset outputs", 32'h1E,
				{27'd0, nSLAVEN_o, nDTACK_o, nBERR_o, nCFGOUT_o, data_oe_o});

		fd = $fopen("test/zorro_patterns.txt", "r");
		if (fd == 0)
			report_error("cannot open test/zorro_patterns.txt");
		while (fd != 0 && !$feof(fd)) begin
			line = "";
			code = $fgets(line, fd);
			if (code == 0 || line.len() < 2 || line.getc(0) == "#")
				continue;
			code = $sscanf(line, "%s %h %h %h %h %h", op, p_addr, p_fc, p_nds, p_wdata, p_exp);
			if (code != 6) begin
				report_error("malformed line in pattern file");
				continue;
			end
			test_no++;
			errs_before = err_cnt;
			nds = p_nds[3:0];
			if (op == "CR") begin
				op_name = "config read";
				bus_read(p_addr, p_fc[1:0], nds, rdata, ok);
				// nibble on d31..d28 with ones below
				if (ok && rdata !== {p_exp[3:0], 28'hFFFFFFF})
					report_mismatch("rdata_o", {p_exp[3:0], 28'hFFFFFFF}, rdata);
				if (nCFGOUT_o !== 1'b1)
					report_mismatch("nCFGOUT_o", 32'd1, {31'd0, nCFGOUT_o});
			end else if (op == "CW") begin
				op_name = "config write";
				bus_write(p_addr, p_fc[1:0], nds, p_wdata, ok);
				if (nCFGOUT_o !== p_exp[0])
					report_mismatch("nCFGOUT_o", p_exp, {31'd0, nCFGOUT_o});
			end else if (op == "CN" || op == "NM") begin
				op_name = (op == "CN") ? "config after setup" : "no match";
				start_cycle(p_addr, p_fc[1:0], 1'b1, SLAVEN_WAIT, seen, ack_seen);
				if (seen)
					report_error($sformatf("card answered access at %h fc %0d", p_addr, p_fc));
				if (ack_seen)
					report_error($sformatf("nDTACK low for unclaimed access at %h", p_addr));
				end_cycle();
			end else if (op == "WR") begin
				op_name = "write and read back";
				wdata = p_wdata;
				// flag 1 asks for random data and strobes
				if (p_exp[0]) begin
					rng_state = xorshift32(rng_state);
					wdata = rng_state;
					rng_state = xorshift32(rng_state);
					nds = (rng_state[3:0] == 4'hF) ? 4'h0 : rng_state[3:0];
				end
				bus_write(p_addr, p_fc[1:0], nds, wdata, ok);
				if (ok)
					model_write(p_addr, nds, wdata);
				bus_read(p_addr, p_fc[1:0], 4'h0, rdata, ok);
				if (ok)
					check_readback(p_addr, rdata);
			end else if (op == "RD") begin
				op_name = "read";
				bus_read(p_addr, p_fc[1:0], nds, rdata, ok);
				if (ok)
					check_readback(p_addr, rdata);
			end else if (op == "BURST") begin
				op_name = "posted burst";
				// three words rewritten in turn so the last value wins
				for (i = 0; i < int'(p_exp); i++) begin
					rng_state = xorshift32(rng_state);
					a = p_addr + 32'(4 * (i % 3));
					bus_write(a, p_fc[1:0], nds, rng_state, ok);
					if (ok)
						model_write(a, nds, rng_state);
				end
				for (i = 0; i < 3; i++) begin
					a = p_addr + 32'(4 * i);
					bus_read(a, p_fc[1:0], 4'h0, rdata, ok);
					if (ok)
						check_readback(a, rdata);
				end
			end else if (op == "TMO") begin
				op_name = "dtack hold";
				start_cycle(p_addr, p_fc[1:0], 1'b1, SLAVEN_WAIT, seen, ack_seen);
				if (seen)
					data_phase(nds, p_addr, DTACK_WAIT, seen);
				if (!seen) begin
					report_error($sformatf("hold test at %h never reached nDTACK", p_addr));
				end else begin
					// master keeps nFCS low past the limit
					n = 0;
					while (nBERR_o && n < DTACK_TIMEOUT + 4) begin
						@(negedge clk);
						n++;
					end
					if (nBERR_o !== 1'b0)
						report_error("nBERR not asserted while nDTACK was held");
					repeat (4) @(negedge clk);
					if (nBERR_o !== 1'b0)
						report_mismatch("nBERR_o", 32'd0, {31'd0, nBERR_o});
					if (nDTACK_o !== 1'b1)
						report_mismatch("nDTACK_o", 32'd1, {31'd0, nDTACK_o});
				end
				end_cycle();
			end else begin
				op_name = "unknown";
				report_error("unknown operation in pattern file");
			end
			if (err_cnt == errs_before)
				pass_cnt++;
			$display("test %0d %s at %h: %s", test_no, op_name, p_addr,
				(err_cnt == errs_before) ? "ok" : "failed");
		end
		if (fd != 0)
			$fclose(fd);

		$display("tests %0d, passed %0d, failed %0d, errors %0d", test_no, pass_cnt,
			test_no - pass_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

//--- test/zorro_patterns.txt
# op addr fc strobes wdata expect, all hex; strobes active low, strobe 3 on d31..d24
# expect: CR nibble, CW nCFGOUT after write, WR 1 for random data and strobes, BURST count
CR FF000000 1 0 00000000 A
CR FF000100 1 0 00000000 2
CR FF000004 2 0 00000000 0
CR FF000104 1 0 00000000 7
CR FF000008 1 0 00000000 3
CR FF000108 2 0 00000000 0
CR FF00000C 1 0 00000000 F
NM FF000000 0 0 00000000 0
NM 40000000 1 0 00000000 0
CW FF000044 1 0 40000000 0
CN FF000000 1 0 00000000 0
WR 40000000 1 0 CAFEF00D 0
RD 40001000 1 0 00000000 0
WR 40000004 1 0 00000000 1
WR 40000004 1 0 00000000 1
WR 40000008 2 0 00000000 1
WR 40000FFC 1 0 00000000 1
WR 43FFFFFC 2 0 00000000 1
WR 40000010 1 C 89ABCDEF 0
WR 40000010 1 3 01234567 0
WR 40000204 2 0 00000000 1
WR 40000204 1 0 00000000 1
BURST 40000100 1 0 00000000 6
BURST 40000300 2 0 00000000 9
NM 40000000 0 0 00000000 0
NM 40000000 3 0 00000000 0
NM 80000000 1 0 00000000 0
NM 3C000000 2 0 00000000 0
TMO 40000004 1 0 00000000 0
RD 40000004 1 0 00000000 0

//--- build.f
design/zorro_bus_pkg.sv
design/card_pkg.sv
design/zorro_cycle_fsm.sv
design/autoconfig_regs.sv
design/write_post_fifo.sv
design/card_memory.sv
design/zorro_ram_card.sv
test/zorro_bus_assert.sv
test/tb_zorro_ram_card.sv

//--- Makefile
TOOL   = verilator
FLAGS  = --binary --timing --assert -Wno-fatal
TOP    = tb_zorro_ram_card
FLIST  = build.f
OBJDIR = obj_dir
LOG    = sim.log

.PHONY: sim clean

# build, run, then look for the pass line in the log
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
